//--- source/sprite_pkg.sv
//----------------------------------------
// Sprite compositor shared definitions
// Widths, colour and config word types
//----------------------------------------
package sprite_pkg;

    //----------------------------------------
    // Widths and screen geometry
    //----------------------------------------
    localparam int COORD_W         = 9;                 // Covers 0..511
    localparam int PAL_IDX_W       = 4;
    localparam int PAL_DEPTH       = 1 << PAL_IDX_W;    // 16 palette entries
    localparam int CFG_ADDR_W      = 4;
    localparam int SCREEN_W        = 320;
    localparam int SCREEN_H        = 240;
    localparam int BKG_CELL_LOG2   = 3;                 // 8 pixel checker cell
    localparam int PAL_SPRITE_BASE = 2;                 // Entries 0 and 1 are background

    //----------------------------------------
    // Data types
    //----------------------------------------
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic [5:0]         pad;                        // Keeps the word at 24 bits
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
    } sprite_pos_t;

    // Same 24 bits, meaning set by the write target
    typedef union packed {
        sprite_pos_t pos;
        rgb_t        rgb;
    } cfg_word_t;

    typedef enum logic [0:0] {
        CFG_POSITION = 1'b0,
        CFG_PALETTE  = 1'b1
    } cfg_target_e;

endpackage

//--- source/pixel_stage_if.sv
//----------------------------------------
// Pixel link between pipeline stages
// Valid/ready handshake with coordinate
//----------------------------------------
`timescale 1ns/1ns

interface pixel_stage_if;

    logic                             valid;     // Driven by the source
    logic                             ready;     // Driven by the sink
    logic [sprite_pkg::COORD_W-1:0]   x;
    logic [sprite_pkg::COORD_W-1:0]   y;
    logic [sprite_pkg::PAL_IDX_W-1:0] pal_idx;   // Resolved object colour index

    modport src (
        output valid,
        output x,
        output y,
        output pal_idx,
        input  ready
    );

    modport dst (
        input  valid,
        input  x,
        input  y,
        input  pal_idx,
        output ready
    );

endinterface

//--- source/config_decode.sv
//----------------------------------------
// Configuration write decoder
// Splits a write into position or palette
//----------------------------------------
`timescale 1ns/1ns

module config_decode #(
    parameter int SPRITE_NUM = 3
) (
    input  logic                                Clk,
    input  logic                                arst_n,
    input  logic                                cfg_valid,
    input  sprite_pkg::cfg_target_e             cfg_target,
    input  logic [sprite_pkg::CFG_ADDR_W-1:0]   cfg_addr,
    input  sprite_pkg::cfg_word_t               cfg_word,
    output logic                                pos_wr_en,
    output logic [sprite_pkg::CFG_ADDR_W-1:0]   pos_wr_id,
    output sprite_pkg::sprite_pos_t             pos_wr_pos,
    output logic                                pal_wr_en,
    output logic [sprite_pkg::PAL_IDX_W-1:0]    pal_wr_idx,
    output sprite_pkg::rgb_t                    pal_wr_rgb
);

    localparam int ADDR_W = sprite_pkg::CFG_ADDR_W;
    localparam logic [ADDR_W:0] SPRITE_LIMIT = (ADDR_W + 1)'(SPRITE_NUM);

    logic                       cfg_valid_q;
    sprite_pkg::cfg_target_e    target_q;
    logic [ADDR_W-1:0]          addr_q;
    sprite_pkg::cfg_word_t      word_q;
    logic                       sprite_ok;

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_valid_q <= 1'b0;
        end else begin
            cfg_valid_q <= cfg_valid;                    // One write per cycle
        end
    end

    always_ff @(posedge Clk) begin
        if (cfg_valid) begin
            target_q <= cfg_target;
            addr_q   <= cfg_addr;
            word_q   <= cfg_word;
        end
    end

    assign sprite_ok = {1'b0, addr_q} < SPRITE_LIMIT;    // Drop writes to missing sprites

    //----------------------------------------
    // Strobes and union decode
    //----------------------------------------
    assign pos_wr_en  = cfg_valid_q && (target_q == sprite_pkg::CFG_POSITION) && sprite_ok;
    assign pos_wr_id  = addr_q;
    assign pos_wr_pos = word_q.pos;

    assign pal_wr_en  = cfg_valid_q && (target_q == sprite_pkg::CFG_PALETTE);
    assign pal_wr_idx = addr_q;
    assign pal_wr_rgb = word_q.rgb;                      // Same bits read as a colour

endmodule

//--- source/sprite_hit_stage.sv
//----------------------------------------
// Sprite hit stage
// Resolves the covering object per pixel
//----------------------------------------
`timescale 1ns/1ns

module sprite_hit_stage #(
    parameter int SPRITE_NUM  = 3,
    parameter int SPRITE_SIZE = 16
) (
    input  logic                                Clk,
    input  logic                                arst_n,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  logic [sprite_pkg::COORD_W-1:0]      in_x,
    input  logic [sprite_pkg::COORD_W-1:0]      in_y,
    input  logic                                pos_wr_en,
    input  logic [sprite_pkg::CFG_ADDR_W-1:0]   pos_wr_id,
    input  sprite_pkg::sprite_pos_t             pos_wr_pos,
    pixel_stage_if.src                          out
);

    localparam int CW     = sprite_pkg::COORD_W;
    localparam int EXT_W  = CW + 1;                      // No wrap past 511
    localparam int IDX_W  = sprite_pkg::PAL_IDX_W;
    localparam int ADDR_W = sprite_pkg::CFG_ADDR_W;
    localparam int CELL   = sprite_pkg::BKG_CELL_LOG2;
    localparam logic [EXT_W-1:0] SIZE_EXT = EXT_W'(SPRITE_SIZE);

    logic [CW-1:0]          spr_x [SPRITE_NUM];
    logic [CW-1:0]          spr_y [SPRITE_NUM];
    logic                   a_valid;                     // Coordinate register stage
    logic [CW-1:0]          a_x;
    logic [CW-1:0]          a_y;
    logic                   a_ready;
    logic                   b_load;
    logic [SPRITE_NUM-1:0]  covers;
    logic [IDX_W-1:0]       hit_idx;

    //----------------------------------------
    // Sprite position registers
    //----------------------------------------
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < SPRITE_NUM; i++) begin
                spr_x[i] <= '1;                          // Parked off screen
                spr_y[i] <= '1;
            end
        end else begin
            for (int i = 0; i < SPRITE_NUM; i++) begin
                if (pos_wr_en && (pos_wr_id == ADDR_W'(i))) begin
                    spr_x[i] <= pos_wr_pos.x;
                    spr_y[i] <= pos_wr_pos.y;
                end
            end
        end
    end

    // Square from pos to pos+SIZE-1 on both axes
    for (genvar k = 0; k < SPRITE_NUM; k++) begin : g_cover
        assign covers[k] = ({1'b0, a_x} >= {1'b0, spr_x[k]}) &&
                           ({1'b0, a_x} <  ({1'b0, spr_x[k]} + SIZE_EXT)) &&
                           ({1'b0, a_y} >= {1'b0, spr_y[k]}) &&
                           ({1'b0, a_y} <  ({1'b0, spr_y[k]} + SIZE_EXT));
    end

    always_comb begin
        hit_idx = {{(IDX_W - 1){1'b0}}, a_x[CELL] ^ a_y[CELL]};   // Checker background
        for (int k = SPRITE_NUM - 1; k >= 0; k--) begin
            if (covers[k]) begin
                hit_idx = IDX_W'(k + sprite_pkg::PAL_SPRITE_BASE);  // Lowest number wins
            end
        end
    end

    //----------------------------------------
    // Two register pipeline
    //----------------------------------------
    assign b_load   = !out.valid || out.ready;
    assign a_ready  = !a_valid || b_load;
    assign in_ready = a_ready;

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            a_valid   <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            if (a_ready) a_valid <= in_valid;
            if (b_load) out.valid <= a_valid;
        end
    end

    always_ff @(posedge Clk) begin
        if (in_valid && a_ready) begin
            a_x <= in_x;
            a_y <= in_y;
        end
        if (a_valid && b_load) begin
            out.x       <= a_x;
            out.y       <= a_y;
            out.pal_idx <= hit_idx;
        end
    end

endmodule

//--- source/palette_stage.sv
//----------------------------------------
// Palette lookup stage
// 16-entry colour table, registered read
//----------------------------------------
`timescale 1ns/1ns

module palette_stage (
    input  logic                                Clk,
    input  logic                                arst_n,
    input  logic                                pal_wr_en,
    input  logic [sprite_pkg::PAL_IDX_W-1:0]    pal_wr_idx,
    input  sprite_pkg::rgb_t                    pal_wr_rgb,
    pixel_stage_if.dst                          in,
    pixel_stage_if.src                          out,
    output sprite_pkg::rgb_t                    stage_rgb
);

    sprite_pkg::rgb_t palette [sprite_pkg::PAL_DEPTH];

    //----------------------------------------
    // Palette storage
    //----------------------------------------
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < sprite_pkg::PAL_DEPTH; i++) begin
                palette[i] <= '0;                        // All black at start
            end
        end else if (pal_wr_en) begin
            palette[pal_wr_idx] <= pal_wr_rgb;
        end
    end

    //----------------------------------------
    // Lookup register
    //----------------------------------------
    assign in.ready = !out.valid || out.ready;           // Empty or draining

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            out.valid <= 1'b0;
        end else if (in.ready) begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge Clk) begin
        if (in.valid && in.ready) begin
            out.x       <= in.x;
            out.y       <= in.y;
            stage_rgb   <= palette[in.pal_idx];          // Colour rides beside the link
        end
    end

endmodule

//--- source/pixel_output_stage.sv
//----------------------------------------
// Pixel output buffer
// Two-entry FIFO absorbing back-pressure
//----------------------------------------
`timescale 1ns/1ns

module pixel_output_stage (
    input  logic                            Clk,
    input  logic                            arst_n,
    pixel_stage_if.dst                      in,
    input  sprite_pkg::rgb_t                in_rgb,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic [sprite_pkg::COORD_W-1:0]  out_x,
    output logic [sprite_pkg::COORD_W-1:0]  out_y,
    output sprite_pkg::rgb_t                out_rgb
);

    localparam int CW = sprite_pkg::COORD_W;

    logic [CW-1:0]      mem_x   [2];
    logic [CW-1:0]      mem_y   [2];
    sprite_pkg::rgb_t   mem_rgb [2];
    logic               wr_ptr;
    logic               rd_ptr;
    logic [1:0]         count;                           // 0, 1 or 2 entries
    logic               push;
    logic               pop;

    assign in.ready  = ~count[1];                        // Flop based, no path from out_ready
    assign out_valid = (count != 2'd0);
    assign push      = in.valid && in.ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;                 // Idle or pass-through
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (push) begin
            mem_x[wr_ptr]   <= in.x;
            mem_y[wr_ptr]   <= in.y;
            mem_rgb[wr_ptr] <= in_rgb;
        end
    end

    assign out_x   = mem_x[rd_ptr];
    assign out_y   = mem_y[rd_ptr];
    assign out_rgb = mem_rgb[rd_ptr];

endmodule

//--- source/sprite_compositor_top.sv
//----------------------------------------
// Sprite pixel compositor top level
// Config path and three stage pixel chain
//----------------------------------------
`timescale 1ns/1ns

module sprite_compositor_top #(
    parameter int SPRITE_NUM  = 3,                       // 1 to 14 sprites
    parameter int SPRITE_SIZE = 16
) (
    input  logic                                Clk,
    input  logic                                arst_n,
    input  logic                                cfg_valid,
    input  sprite_pkg::cfg_target_e             cfg_target,
    input  logic [sprite_pkg::CFG_ADDR_W-1:0]   cfg_addr,
    input  sprite_pkg::cfg_word_t               cfg_word,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  logic [sprite_pkg::COORD_W-1:0]      in_x,
    input  logic [sprite_pkg::COORD_W-1:0]      in_y,
    output logic                                out_valid,
    input  logic                                out_ready,
    output logic [sprite_pkg::COORD_W-1:0]      out_x,
    output logic [sprite_pkg::COORD_W-1:0]      out_y,
    output sprite_pkg::rgb_t                    out_rgb
);

    logic                               pos_wr_en;
    logic [sprite_pkg::CFG_ADDR_W-1:0]  pos_wr_id;
    sprite_pkg::sprite_pos_t            pos_wr_pos;
    logic                               pal_wr_en;
    logic [sprite_pkg::PAL_IDX_W-1:0]   pal_wr_idx;
    sprite_pkg::rgb_t                   pal_wr_rgb;
    sprite_pkg::rgb_t                   stage_rgb;

    pixel_stage_if hit_link ();                          // Hit stage to palette
    pixel_stage_if pal_link ();                          // Palette to output buffer

    //----------------------------------------
    // Configuration path
    //----------------------------------------
    config_decode #(
        .SPRITE_NUM (SPRITE_NUM)
    ) i_config_decode (
        .Clk, .arst_n, .cfg_valid, .cfg_target, .cfg_addr, .cfg_word,
        .pos_wr_en, .pos_wr_id, .pos_wr_pos,
        .pal_wr_en, .pal_wr_idx, .pal_wr_rgb
    );

    //----------------------------------------
    // Pixel pipeline
    //----------------------------------------
    sprite_hit_stage #(
        .SPRITE_NUM  (SPRITE_NUM),
        .SPRITE_SIZE (SPRITE_SIZE)
    ) i_sprite_hit_stage (
        .Clk, .arst_n, .in_valid, .in_ready, .in_x, .in_y,
        .pos_wr_en, .pos_wr_id, .pos_wr_pos,
        .out (hit_link.src)
    );

    palette_stage i_palette_stage (
        .Clk, .arst_n, .pal_wr_en, .pal_wr_idx, .pal_wr_rgb,
        .in        (hit_link.dst),
        .out       (pal_link.src),
        .stage_rgb (stage_rgb)
    );

    pixel_output_stage i_pixel_output_stage (
        .Clk, .arst_n,
        .in     (pal_link.dst),
        .in_rgb (stage_rgb),
        .out_valid, .out_ready, .out_x, .out_y, .out_rgb
    );

endmodule

//--- testbench/sprite_compositor_assertions.sv
//----------------------------------------
// Handshake and reset assertions
//----------------------------------------
`timescale 1ns/1ns

module sprite_compositor_assertions (
    input logic             Clk,
    input logic             arst_n,
    input logic             in_valid,
    input logic             in_ready,
    input logic [8:0]       in_x,
    input logic [8:0]       in_y,
    input logic             out_valid,
    input logic             out_ready,
    input logic [8:0]       out_x,
    input logic [8:0]       out_y,
    input logic [23:0]      out_rgb
);

    a_reset_values: assert property (@(posedge Clk) !arst_n |-> !out_valid && in_ready)
        else $error("handshake outputs wrong during reset");

    a_out_stable: assert property (@(posedge Clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable({out_x, out_y, out_rgb}))
        else $error("output data changed while stalled");

    a_in_stable: assert property (@(posedge Clk) disable iff (!arst_n)
        in_valid && !in_ready |=> in_valid && $stable({in_x, in_y}))
        else $error("input data changed while stalled");

endmodule

bind sprite_compositor_top sprite_compositor_assertions i_assertions (.*);

//--- testbench/sprite_compositor_tb.sv
//----------------------------------------
// Sprite compositor testbench
// Random pixels checked against a model
//----------------------------------------
`timescale 1ns/1ns

module sprite_compositor_tb;

    localparam int NUM  = 3;
    localparam int SIZE = 16;

    typedef struct packed {
        sprite_pkg::rgb_t   rgb;
        logic [8:0]         x;
        logic [8:0]         y;
        int                 cyc;                         // Accept cycle
    } exp_pixel_t;

    logic Clk = 1'b0;
    logic arst_n = 1'b0;
    logic cfg_valid = 1'b0;
    sprite_pkg::cfg_target_e cfg_target = sprite_pkg::CFG_POSITION;
    logic [3:0] cfg_addr = '0;
    sprite_pkg::cfg_word_t cfg_word = '0;
    logic in_valid = 1'b0;
    logic in_ready;
    logic [8:0] in_x = '0;
    logic [8:0] in_y = '0;
    logic out_valid;
    logic out_ready = 1'b1;
    logic [8:0] out_x;
    logic [8:0] out_y;
    sprite_pkg::rgb_t out_rgb;

    sprite_pkg::rgb_t model_pal [16];
    int               model_px  [NUM];
    int               model_py  [NUM];
    exp_pixel_t       exp_q [$];
    int    cycle = 0;
    int    ready_mode = 1;                               // 1 high, 0 low, 2 random
    bit    check_latency = 0;
    bit    in_ready_low = 0;
    int    test_errors, total_errors, failed_tests, checks;
    string test_name;
    int    seed;
    event  timeout_ev;
    string timeout_what;

    sprite_compositor_top #(.SPRITE_NUM(NUM), .SPRITE_SIZE(SIZE)) i_dut (.*);

    always #50 Clk = ~Clk;

    always @(posedge Clk) begin
        #1;
        if (ready_mode == 2) out_ready <= 1'($urandom());
        else out_ready <= 1'(ready_mode);
    end

    function automatic sprite_pkg::rgb_t predict_rgb(int x, int y);
        for (int k = 0; k < NUM; k++) begin
            if (x >= model_px[k] && x < model_px[k] + SIZE &&
                y >= model_py[k] && y < model_py[k] + SIZE) return model_pal[k + 2];
        end
        return model_pal[((x >> 3) ^ (y >> 3)) & 1];     // Checker cell
    endfunction

    task automatic report_mismatch(string what, logic [23:0] exp_v, logic [23:0] act_v);
        $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp_v, act_v);
        test_errors++;
    endtask

    //----------------------------------------
    // Monitor on both handshakes
    //----------------------------------------
    always @(posedge Clk) begin
        exp_pixel_t e;
        cycle <= cycle + 1;
        if (arst_n && !in_ready) in_ready_low = 1;
        if (in_valid && in_ready) begin
            e.rgb = predict_rgb(in_x, in_y);
            e.x   = in_x;
            e.y   = in_y;
            e.cyc = cycle;
            exp_q.push_back(e);
        end
        if (out_valid && out_ready) begin
            checks++;
            if (exp_q.size() == 0) begin
                $display("unexpected output pixel in %s", test_name);
                test_errors++;
            end else begin
                e = exp_q.pop_front();
                if (e.rgb != out_rgb) report_mismatch("rgb", e.rgb, out_rgb);
                if (e.x != out_x) report_mismatch("x", 24'(e.x), 24'(out_x));
                if (e.y != out_y) report_mismatch("y", 24'(e.y), 24'(out_y));
                if (check_latency && (cycle - e.cyc != 4))
                    report_mismatch("latency", 24'(4), 24'(cycle - e.cyc));
            end
        end
    end

    task automatic raise_timeout(string what);
        timeout_what = what;
        -> timeout_ev;
    endtask

    initial begin
        @(timeout_ev);
        $display("timeout while waiting for %s in %s", timeout_what, test_name);
        $display("TEST FAILED");
        $finish;
    end

    task automatic cfg_write(sprite_pkg::cfg_target_e t, int addr, logic [23:0] w);
        cfg_valid  = 1'b1;
        cfg_target = t;
        cfg_addr   = 4'(addr);
        cfg_word   = w;
        @(posedge Clk);
        #1 cfg_valid = 1'b0;
        if (t == sprite_pkg::CFG_PALETTE) model_pal[addr] = w;
        else if (addr < NUM) begin
            model_px[addr] = cfg_word.pos.x;
            model_py[addr] = cfg_word.pos.y;
        end
        repeat (2) @(posedge Clk);                       // Write lands after 2 cycles
        #1;
    endtask

    task automatic send_pixel(int x, int y);
        bit seen;
        int n = 0;
        in_valid = 1'b1;
        in_x = 9'(x);
        in_y = 9'(y);
        do begin
            @(negedge Clk) seen = in_ready;
            @(posedge Clk);
            #1;
            if (++n > 200) raise_timeout("in_ready");
        end while (!seen);
    endtask

    task automatic end_burst();
        int n = 0;
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge Clk);
            if (++n > 2000) raise_timeout("pipeline drain");
        end
        #1;
    endtask

    task automatic random_pixels(int count);
        for (int i = 0; i < count; i++)
            send_pixel($urandom_range(sprite_pkg::SCREEN_W - 1),
                       $urandom_range(sprite_pkg::SCREEN_H - 1));
    endtask

    task automatic finish_test();
        $display("done %s checks=%0d errors=%0d", test_name, checks, test_errors);
        total_errors += test_errors;
        if (test_errors != 0) failed_tests++;
        test_errors = 0;
        checks = 0;
    endtask

    initial begin
        int px;
        int py;
        seed = 78;
        void'($urandom(seed));
        for (int i = 0; i < 16; i++) model_pal[i] = '0;
        for (int k = 0; k < NUM; k++) begin
            model_px[k] = 511;
            model_py[k] = 511;
        end
        repeat (5) @(posedge Clk);
        #1 arst_n = 1'b1;

        test_name = "reset";
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("handshake outputs not at reset values after reset");
            test_errors++;
        end
        random_pixels(20);
        end_burst();
        finish_test();

        test_name = "background";
        cfg_write(sprite_pkg::CFG_PALETTE, 0, 24'($urandom()));
        cfg_write(sprite_pkg::CFG_PALETTE, 1, 24'($urandom()));
        check_latency = 1;
        random_pixels(60);
        end_burst();
        check_latency = 0;
        finish_test();

        test_name = "sprites";
        for (int i = 0; i < 16; i++) cfg_write(sprite_pkg::CFG_PALETTE, i, 24'($urandom()));
        for (int k = 0; k < NUM; k++) begin
            px = (k == 1) ? model_px[0] + 5 : $urandom_range(sprite_pkg::SCREEN_W - SIZE);
            py = (k == 1) ? model_py[0] + 7 : $urandom_range(sprite_pkg::SCREEN_H - SIZE);
            cfg_write(sprite_pkg::CFG_POSITION, k, {6'b0, 9'(px), 9'(py)});
        end
        random_pixels(300);
        for (int k = 0; k < NUM; k++) begin
            for (int d = -1; d <= SIZE; d += 1) begin
                send_pixel(model_px[k] + d, model_py[k]);
                send_pixel(model_px[k] - 1, model_py[k] + d);
                send_pixel(model_px[k] + SIZE, model_py[k] + d);
            end
        end
        end_burst();
        finish_test();

        test_name = "backpressure";
        in_ready_low = 0;
        ready_mode = 0;
        random_pixels(5);                                // Fills all five pipeline slots
        in_valid = 1'b0;
        repeat (10) @(posedge Clk);
        #1;
        if (!in_ready_low) begin
            $display("in_ready never fell during a long stall");
            test_errors++;
        end
        ready_mode = 2;
        random_pixels(295);
        end_burst();
        ready_mode = 1;
        finish_test();

        test_name = "config";
        cfg_write(sprite_pkg::CFG_POSITION, NUM, {6'b0, 9'd40, 9'd40});
        cfg_write(sprite_pkg::CFG_POSITION, 15, {6'b0, 9'd100, 9'd60});
        for (int d = 0; d < SIZE; d++) begin
            send_pixel(40 + d, 40 + d);
            send_pixel(100 + d, 60 + d);
        end
        random_pixels(50);
        end_burst();
        cfg_write(sprite_pkg::CFG_PALETTE, 0, 24'($urandom()));
        cfg_write(sprite_pkg::CFG_PALETTE, 2, 24'($urandom()));
        random_pixels(80);
        end_burst();
        finish_test();

        $display("tests=5 failed_tests=%0d errors=%0d", failed_tests, total_errors);
        if (total_errors == 0) $display("TEST OK");
        else $display("TEST FAILED");
        $finish;
    end

endmodule

//--- compile.f
source/sprite_pkg.sv
source/pixel_stage_if.sv
source/config_decode.sv
source/sprite_hit_stage.sv
source/palette_stage.sv
source/pixel_output_stage.sv
source/sprite_compositor_top.sv
testbench/sprite_compositor_assertions.sv
testbench/sprite_compositor_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the sprite compositor simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module sprite_compositor_tb -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
exit 1
